//--- common/isa_pkg.sv
package isa_pkg;

  //////////////////////////////////////////////////
  // instruction fields.
  //////////////////////////////////////////////////

  localparam int INST_WIDTH = 32;
  localparam int OPCODE_LSB = 26;
  localparam int RS_LSB     = 21;
  localparam int RT_LSB     = 16;
  localparam int RD_LSB     = 11;

  // top two bits pick the group: alu, alu imm, memory, branch.
  typedef enum logic [5:0] {
    OP_NOP   = 6'b000000,
    OP_ADD   = 6'b000001,
    OP_SUB   = 6'b000010,
    OP_CMP   = 6'b000011,
    OP_TEST  = 6'b000100,
    OP_ADDI  = 6'b010001,
    OP_SUBI  = 6'b010010,
    OP_CMPI  = 6'b010011,
    OP_TESTI = 6'b010100,
    OP_LW    = 6'b100000,
    OP_SW    = 6'b100001,
    OP_JMP   = 6'b110000,
    OP_JE    = 6'b110001,
    OP_JO    = 6'b110010,
    OP_JR    = 6'b111111
  } opcode_t;

  //////////////////////////////////////////////////
  // register operands.
  //////////////////////////////////////////////////

  typedef logic [4:0] reg_idx_t;

  // one flag per operand slot.
  typedef logic [2:0] reg_mask_t;

  localparam reg_mask_t MASK_SRC0 = 3'b001;
  localparam reg_mask_t MASK_SRC1 = 3'b010;
  localparam reg_mask_t MASK_DEST = 3'b100;

endpackage

//--- common/iq_pkg.sv
package iq_pkg;

  //////////////////////////////////////////////////
  // queue geometry.
  //////////////////////////////////////////////////

  localparam int IQ_DEPTH      = 8;
  localparam int IQ_PUSH_LANES = 2; // entries accepted per cycle.

  typedef logic [$clog2(IQ_DEPTH)-1:0] iq_slot_t;
  typedef logic [$clog2(IQ_DEPTH):0]   iq_count_t;

  //////////////////////////////////////////////////
  // entry payload.
  //////////////////////////////////////////////////

  localparam int PC_WIDTH = 32;
  localparam int ID_WIDTH = 4;

  // lane 0 takes branches, lane 1 takes memory.
  typedef enum logic [1:0] {
    PIPE_ANY    = 2'b00,
    PIPE_BRANCH = 2'b01,
    PIPE_MEMORY = 2'b10
  } pipe_t;

endpackage

//--- hdl/reg_decode.sv
module reg_decode import isa_pkg::*, iq_pkg::*; (
  input  logic [INST_WIDTH-1:0] instruction,
  output reg_idx_t              src0,
  output reg_idx_t              src1,
  output reg_idx_t              dest,
  output reg_mask_t             used,
  output pipe_t                 pipe
);

  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;

  assign opcode = opcode_t'(instruction[OPCODE_LSB +: $bits(opcode_t)]);
  assign rs     = instruction[RS_LSB +: $bits(reg_idx_t)];
  assign rt     = instruction[RT_LSB +: $bits(reg_idx_t)];
  assign rd     = instruction[RD_LSB +: $bits(reg_idx_t)];

  always_comb begin
    src0 = rs;
    src1 = rt;
    dest = rd;
    used = '0;
    case (opcode[5:4])
      2'b00: begin // add, sub, cmp, test.
        if (opcode != OP_NOP) used = MASK_SRC0 | MASK_SRC1 | MASK_DEST;
      end
      2'b01: begin // immediate forms write rt.
        dest = rt;
        used = MASK_SRC0 | MASK_DEST;
      end
      2'b10: begin
        if (opcode == OP_LW) begin
          dest = rt;
          used = MASK_SRC0 | MASK_DEST;
        end else if (opcode == OP_SW) begin
          used = MASK_SRC0 | MASK_SRC1; // base and store data.
        end
      end
      default: begin
        if (opcode == OP_JR) used = MASK_SRC0;
      end
    endcase
  end

  // compares feed the branch unit, so they steer with branches.
  always_comb begin
    case (opcode[5:4])
      2'b10:   pipe = PIPE_MEMORY;
      2'b11:   pipe = PIPE_BRANCH;
      default: pipe = (opcode inside {OP_CMP, OP_TEST, OP_CMPI, OP_TESTI}) ? PIPE_BRANCH
                                                                         : PIPE_ANY;
    endcase
  end

endmodule

//--- queue/issue_queue.sv
module issue_queue import isa_pkg::*, iq_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  iq_count_t             count,

  input  logic                  push0,
  input  logic                  push1,
  input  logic [INST_WIDTH-1:0] instruction0_in,
  input  logic [INST_WIDTH-1:0] instruction1_in,
  input  logic [PC_WIDTH-1:0]   pc0_in,
  input  logic [PC_WIDTH-1:0]   pc1_in,
  input  logic [ID_WIDTH-1:0]   id0_in,
  input  logic [ID_WIDTH-1:0]   id1_in,

  input  logic                  issue_a,
  input  logic                  issue_b,
  input  iq_slot_t              pick_b,

  output logic [IQ_DEPTH-1:0]   slot_valid,
  output logic [INST_WIDTH-1:0] slot_instruction [IQ_DEPTH],
  output logic [PC_WIDTH-1:0]   slot_pc          [IQ_DEPTH],
  output logic [ID_WIDTH-1:0]   slot_id          [IQ_DEPTH]
);

  logic [INST_WIDTH-1:0] inst_d [IQ_DEPTH];
  logic [PC_WIDTH-1:0]   pc_d   [IQ_DEPTH];
  logic [ID_WIDTH-1:0]   id_d   [IQ_DEPTH];
  iq_count_t             keep;

  assign keep = count - iq_count_t'(issue_a) - iq_count_t'(issue_b);

  always_comb begin
    for (int k = 0; k < IQ_DEPTH; k++) begin
      slot_valid[k] = iq_count_t'(k) < count;
    end
  end

  //////////////////////////////////////////////////
  // collapse and append.
  //////////////////////////////////////////////////

  always_comb begin
    iq_count_t src;
    for (int k = 0; k < IQ_DEPTH; k++) begin
      // slot 0 leaves first, then everything at or above pick_b moves one more.
      src = iq_count_t'(k) + iq_count_t'(issue_a);
      if (issue_b && src >= iq_count_t'(pick_b)) src = src + 1'b1;

      inst_d[k] = slot_instruction[k];
      pc_d[k]   = slot_pc[k];
      id_d[k]   = slot_id[k];
      if (iq_count_t'(k) < keep) begin
        inst_d[k] = slot_instruction[iq_slot_t'(src)];
        pc_d[k]   = slot_pc[iq_slot_t'(src)];
        id_d[k]   = slot_id[iq_slot_t'(src)];
      end else if (push0 && iq_count_t'(k) == keep) begin
        inst_d[k] = instruction0_in;
        pc_d[k]   = pc0_in;
        id_d[k]   = id0_in;
      end else if (push1 && iq_count_t'(k) == keep + 1'b1) begin
        inst_d[k] = instruction1_in; // lane 1 is the younger push.
        pc_d[k]   = pc1_in;
        id_d[k]   = id1_in;
      end
    end
  end

  // empty slots come up as nop.
  always_ff @(posedge clk) begin
    if (reset) begin
      slot_instruction <= '{default: '0};
    end else begin
      slot_instruction <= inst_d;
    end
  end

  always_ff @(posedge clk) begin
    slot_pc <= pc_d;
    slot_id <= id_d;
  end

endmodule

//--- queue/occupancy_counter.sv
module occupancy_counter import iq_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      flush,
  input  logic      push0,
  input  logic      push1,
  input  logic      issue_a,
  input  logic      issue_b,
  output iq_count_t count,
  output iq_count_t free,
  output logic      stall
);

  iq_count_t removed;
  iq_count_t added;

  assign removed = iq_count_t'(issue_a) + iq_count_t'(issue_b);
  assign added   = iq_count_t'(push0) + iq_count_t'(push1);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      count <= '0;
    end else begin
      count <= count - removed + added;
    end
  end

  assign free = iq_count_t'(IQ_DEPTH) - count;

  // upstream may push two, so hold it off below that.
  assign stall = free < iq_count_t'(IQ_PUSH_LANES);

endmodule

//--- select/order_hazard.sv
module order_hazard import isa_pkg::*, iq_pkg::*; (
  input  logic [IQ_DEPTH-1:0] slot_valid,
  input  reg_idx_t            src0   [IQ_DEPTH],
  input  reg_idx_t            src1   [IQ_DEPTH],
  input  reg_idx_t            dest   [IQ_DEPTH],
  input  reg_mask_t           used   [IQ_DEPTH],
  input  opcode_t             opcode [IQ_DEPTH],
  output logic [IQ_DEPTH-1:0] ready
);

  //////////////////////////////////////////////////
  // opcode classes.
  //////////////////////////////////////////////////

  function automatic logic is_branch(opcode_t op);
    return (op[5:4] == 2'b11) && (op != OP_JMP); // jmp never stalls anyone.
  endfunction

  function automatic logic is_cmp(opcode_t op);
    return op inside {OP_CMP, OP_TEST, OP_CMPI, OP_TESTI};
  endfunction

  function automatic logic is_mem(opcode_t op);
    return op inside {OP_LW, OP_SW};
  endfunction

  function automatic logic reads_reg(reg_idx_t s0, reg_idx_t s1, reg_mask_t u, reg_idx_t r);
    return (((u & MASK_SRC0) != '0) && (s0 == r)) ||
           (((u & MASK_SRC1) != '0) && (s1 == r));
  endfunction

  function automatic logic writes(reg_mask_t u);
    return (u & MASK_DEST) != '0;
  endfunction

  //////////////////////////////////////////////////
  // pairwise check against every older slot.
  //////////////////////////////////////////////////

  always_comb begin
    logic raw;
    logic war;
    logic waw;
    logic order;
    logic head;
    ready[0] = slot_valid[0]; // oldest, nothing ahead of it.
    for (int i = 1; i < IQ_DEPTH; i++) begin
      ready[i] = slot_valid[i];
      for (int j = 0; j < i; j++) begin
        head = (j == 0); // slot 0 issues this cycle or earlier.
        raw = writes(used[j]) && reads_reg(src0[i], src1[i], used[i], dest[j]);
        war = writes(used[i]) && reads_reg(src0[j], src1[j], used[j], dest[i]);
        waw = writes(used[i]) && writes(used[j]) && (dest[i] == dest[j]);

        order = (is_branch(opcode[j]) && !head) ||
                (is_branch(opcode[i]) && i > 1) ||
                (is_branch(opcode[i]) && is_cmp(opcode[j])) ||
                (is_cmp(opcode[i]) && is_branch(opcode[j])) ||
                (is_mem(opcode[i]) && is_mem(opcode[j]));

        if (slot_valid[j] && (raw || ((war || waw) && !head) || order)) ready[i] = 1'b0;
      end
    end
  end

endmodule

//--- select/dual_select.sv
module dual_select import isa_pkg::*, iq_pkg::*; (
  input  logic [IQ_DEPTH-1:0]   ready,
  input  pipe_t                 pipe             [IQ_DEPTH],
  input  logic [INST_WIDTH-1:0] slot_instruction [IQ_DEPTH],
  input  logic [PC_WIDTH-1:0]   slot_pc          [IQ_DEPTH],
  input  logic [ID_WIDTH-1:0]   slot_id          [IQ_DEPTH],

  output logic                  issue_a,
  output logic                  issue_b,
  output iq_slot_t              pick_b,

  output logic                  lane0_valid,
  output logic [INST_WIDTH-1:0] lane0_instruction,
  output logic [PC_WIDTH-1:0]   lane0_pc,
  output logic [ID_WIDTH-1:0]   lane0_id,

  output logic                  lane1_valid,
  output logic [INST_WIDTH-1:0] lane1_instruction,
  output logic [PC_WIDTH-1:0]   lane1_pc,
  output logic [ID_WIDTH-1:0]   lane1_id
);

  logic     a_on_lane1;
  iq_slot_t lane0_slot;
  iq_slot_t lane1_slot;

  function automatic logic pipe_clash(pipe_t a, pipe_t b);
    return (a == b) && (a != PIPE_ANY);
  endfunction

  assign issue_a = ready[0]; // oldest always goes.

  // walk down so the lowest eligible slot wins.
  always_comb begin
    issue_b = 1'b0;
    pick_b  = '0;
    for (int i = IQ_DEPTH - 1; i > 0; i--) begin
      if (issue_a && ready[i] && !pipe_clash(pipe[0], pipe[i])) begin
        issue_b = 1'b1;
        pick_b  = iq_slot_t'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // lane steering.
  //////////////////////////////////////////////////

  assign a_on_lane1 = (pipe[0] == PIPE_MEMORY) || (issue_b && pipe[pick_b] == PIPE_BRANCH);

  assign lane0_slot = a_on_lane1 ? pick_b : iq_slot_t'(0);
  assign lane1_slot = a_on_lane1 ? iq_slot_t'(0) : pick_b;

  assign lane0_valid = issue_b || (issue_a && !a_on_lane1);
  assign lane1_valid = issue_b || (issue_a && a_on_lane1);

  assign lane0_instruction = lane0_valid ? slot_instruction[lane0_slot] : '0;
  assign lane0_pc          = lane0_valid ? slot_pc[lane0_slot]          : '0;
  assign lane0_id          = lane0_valid ? slot_id[lane0_slot]          : '0;

  assign lane1_instruction = lane1_valid ? slot_instruction[lane1_slot] : '0;
  assign lane1_pc          = lane1_valid ? slot_pc[lane1_slot]          : '0;
  assign lane1_id          = lane1_valid ? slot_id[lane1_slot]          : '0;

endmodule

//--- hdl/issue_stage.sv
module issue_stage import isa_pkg::*, iq_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,

  input  logic                  push0,
  input  logic                  push1,
  input  logic [INST_WIDTH-1:0] instruction0_in,
  input  logic [INST_WIDTH-1:0] instruction1_in,
  input  logic [PC_WIDTH-1:0]   pc0_in,
  input  logic [PC_WIDTH-1:0]   pc1_in,
  input  logic [ID_WIDTH-1:0]   id0_in,
  input  logic [ID_WIDTH-1:0]   id1_in,

  output logic                  stall,
  output iq_count_t             free,

  output logic                  lane0_valid,
  output logic [INST_WIDTH-1:0] lane0_instruction,
  output logic [PC_WIDTH-1:0]   lane0_pc,
  output logic [ID_WIDTH-1:0]   lane0_id,

  output logic                  lane1_valid,
  output logic [INST_WIDTH-1:0] lane1_instruction,
  output logic [PC_WIDTH-1:0]   lane1_pc,
  output logic [ID_WIDTH-1:0]   lane1_id
);

  iq_count_t             count;
  logic                  issue_a;
  logic                  issue_b;
  iq_slot_t              pick_b;

  logic [IQ_DEPTH-1:0]   slot_valid;
  logic [IQ_DEPTH-1:0]   live_valid;
  logic [IQ_DEPTH-1:0]   ready;
  logic [INST_WIDTH-1:0] slot_instruction [IQ_DEPTH];
  logic [PC_WIDTH-1:0]   slot_pc          [IQ_DEPTH];
  logic [ID_WIDTH-1:0]   slot_id          [IQ_DEPTH];

  opcode_t               opcode [IQ_DEPTH];
  reg_idx_t              src0   [IQ_DEPTH];
  reg_idx_t              src1   [IQ_DEPTH];
  reg_idx_t              dest   [IQ_DEPTH];
  reg_mask_t             used   [IQ_DEPTH];
  pipe_t                 pipe   [IQ_DEPTH];

  // nothing issues while the window is being thrown away.
  assign live_valid = slot_valid & {IQ_DEPTH{~flush}};

  occupancy_counter u_counter (
    .clk     (clk),
    .reset   (reset),
    .flush   (flush),
    .push0   (push0),
    .push1   (push1),
    .issue_a (issue_a),
    .issue_b (issue_b),
    .count   (count),
    .free    (free),
    .stall   (stall)
  );

  issue_queue u_queue (
    .clk              (clk),
    .reset            (reset),
    .count            (count),
    .push0            (push0),
    .push1            (push1),
    .instruction0_in  (instruction0_in),
    .instruction1_in  (instruction1_in),
    .pc0_in           (pc0_in),
    .pc1_in           (pc1_in),
    .id0_in           (id0_in),
    .id1_in           (id1_in),
    .issue_a          (issue_a),
    .issue_b          (issue_b),
    .pick_b           (pick_b),
    .slot_valid       (slot_valid),
    .slot_instruction (slot_instruction),
    .slot_pc          (slot_pc),
    .slot_id          (slot_id)
  );

  //////////////////////////////////////////////////
  // per-slot decode.
  //////////////////////////////////////////////////

  for (genvar g = 0; g < IQ_DEPTH; g++) begin : g_decode
    assign opcode[g] = opcode_t'(slot_instruction[g][OPCODE_LSB +: $bits(opcode_t)]);

    reg_decode u_decode (
      .instruction (slot_instruction[g]),
      .src0        (src0[g]),
      .src1        (src1[g]),
      .dest        (dest[g]),
      .used        (used[g]),
      .pipe        (pipe[g])
    );
  end

  order_hazard u_hazard (
    .slot_valid (live_valid),
    .src0       (src0),
    .src1       (src1),
    .dest       (dest),
    .used       (used),
    .opcode     (opcode),
    .ready      (ready)
  );

  dual_select u_select (
    .ready             (ready),
    .pipe              (pipe),
    .slot_instruction  (slot_instruction),
    .slot_pc           (slot_pc),
    .slot_id           (slot_id),
    .issue_a           (issue_a),
    .issue_b           (issue_b),
    .pick_b            (pick_b),
    .lane0_valid       (lane0_valid),
    .lane0_instruction (lane0_instruction),
    .lane0_pc          (lane0_pc),
    .lane0_id          (lane0_id),
    .lane1_valid       (lane1_valid),
    .lane1_instruction (lane1_instruction),
    .lane1_pc          (lane1_pc),
    .lane1_id          (lane1_id)
  );

endmodule

//--- sim/clock_gen.sv
module clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 20; // full period of 40.

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

//--- sim/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

//////////////////////////////////////////////////
// operand and class decode.
//////////////////////////////////////////////////

function automatic opcode_t op_of(logic [INST_WIDTH-1:0] inst);
  return opcode_t'(inst[31:26]);
endfunction

function automatic logic is_alu_rr(logic [INST_WIDTH-1:0] inst);
  return op_of(inst) inside {OP_ADD, OP_SUB, OP_CMP, OP_TEST};
endfunction

function automatic logic writes_ref(logic [INST_WIDTH-1:0] inst);
  return is_alu_rr(inst) || (op_of(inst) inside {OP_ADDI, OP_SUBI, OP_CMPI, OP_TESTI, OP_LW});
endfunction

function automatic logic [4:0] dest_ref(logic [INST_WIDTH-1:0] inst);
  return is_alu_rr(inst) ? inst[15:11] : inst[20:16]; // rd for reg-reg, rt otherwise.
endfunction

// every writer reads rs, so do sw and jr.
function automatic logic reads_ref(logic [INST_WIDTH-1:0] inst, logic [4:0] r);
  logic rs_read;
  logic rt_read;
  rs_read = writes_ref(inst) || (op_of(inst) inside {OP_SW, OP_JR});
  rt_read = is_alu_rr(inst) || (op_of(inst) == OP_SW);
  return (rs_read && inst[25:21] == r) || (rt_read && inst[20:16] == r);
endfunction

function automatic logic is_cond_branch(logic [INST_WIDTH-1:0] inst);
  return op_of(inst) inside {OP_JE, OP_JO, OP_JR};
endfunction

function automatic logic is_compare(logic [INST_WIDTH-1:0] inst);
  return op_of(inst) inside {OP_CMP, OP_TEST, OP_CMPI, OP_TESTI};
endfunction

function automatic logic is_mem(logic [INST_WIDTH-1:0] inst);
  return op_of(inst) inside {OP_LW, OP_SW};
endfunction

function automatic pipe_t pipe_ref(logic [INST_WIDTH-1:0] inst);
  if (is_mem(inst)) return PIPE_MEMORY;
  if (is_compare(inst) || op_of(inst) inside {OP_JMP, OP_JE, OP_JO, OP_JR}) return PIPE_BRANCH;
  return PIPE_ANY;
endfunction

//////////////////////////////////////////////////
// readiness and lane routing on the mirror.
//////////////////////////////////////////////////

function automatic logic slot_ready(int i);
  logic [INST_WIDTH-1:0] a;
  logic [INST_WIDTH-1:0] b;
  if (i >= q_count) return 1'b0;
  if (i == 0) return 1'b1;
  a = q_inst[i];
  for (int j = 0; j < i; j++) begin
    b = q_inst[j];
    if (writes_ref(b) && reads_ref(a, dest_ref(b))) return 1'b0;
    if (j > 0 && writes_ref(a) && reads_ref(b, dest_ref(a))) return 1'b0;
    if (j > 0 && writes_ref(a) && writes_ref(b) && dest_ref(a) == dest_ref(b)) return 1'b0;
    if ((j > 0 && is_cond_branch(b)) || (i > 1 && is_cond_branch(a))) return 1'b0;
    if ((is_cond_branch(a) && is_compare(b)) || (is_compare(a) && is_cond_branch(b))) return 1'b0;
    if (is_mem(a) && is_mem(b)) return 1'b0;
  end
  return 1'b1;
endfunction

function automatic void predict(input logic flushing);
  logic  a_lane1;
  pipe_t pipe_a;
  pipe_a     = pipe_ref(q_inst[0]);
  exp_a      = !flushing && q_count > 0;
  exp_b      = 1'b0;
  exp_slot_b = 0;
  for (int i = 1; i < IQ_DEPTH; i++) begin
    if (exp_a && !exp_b && slot_ready(i) &&
        !(pipe_a == pipe_ref(q_inst[i]) && pipe_a != PIPE_ANY)) begin
      exp_b      = 1'b1;
      exp_slot_b = i;
    end
  end
  if (exp_b) a_lane1 = pipe_a == PIPE_MEMORY || pipe_ref(q_inst[exp_slot_b]) == PIPE_BRANCH;
  else a_lane1 = pipe_a == PIPE_MEMORY;
  exp_l0_valid = exp_b || (exp_a && !a_lane1);
  exp_l1_valid = exp_b || (exp_a && a_lane1);
  exp_l0_slot  = a_lane1 ? exp_slot_b : 0;
  exp_l1_slot  = a_lane1 ? 0 : exp_slot_b;
endfunction

`endif

//--- sim/tb_issue_stage.sv
module tb_issue_stage import isa_pkg::*, iq_pkg::*; ();

  localparam int WAIT_LIMIT = 40; // cycles.
  localparam opcode_t OP_LIST [15] = '{OP_NOP, OP_ADD, OP_SUB, OP_CMP, OP_TEST, OP_ADDI,
      OP_SUBI, OP_CMPI, OP_TESTI, OP_LW, OP_SW, OP_JMP, OP_JE, OP_JO, OP_JR};

  logic                  clk;
  logic                  reset;
  logic                  flush;
  logic                  push0;
  logic                  push1;
  logic [INST_WIDTH-1:0] instruction0_in;
  logic [INST_WIDTH-1:0] instruction1_in;
  logic [PC_WIDTH-1:0]   pc0_in;
  logic [PC_WIDTH-1:0]   pc1_in;
  logic [ID_WIDTH-1:0]   id0_in;
  logic [ID_WIDTH-1:0]   id1_in;
  logic                  stall;
  iq_count_t             free;
  logic                  lane0_valid;
  logic [INST_WIDTH-1:0] lane0_instruction;
  logic [PC_WIDTH-1:0]   lane0_pc;
  logic [ID_WIDTH-1:0]   lane0_id;
  logic                  lane1_valid;
  logic [INST_WIDTH-1:0] lane1_instruction;
  logic [PC_WIDTH-1:0]   lane1_pc;
  logic [ID_WIDTH-1:0]   lane1_id;

  // queue mirror, oldest first.
  logic [INST_WIDTH-1:0] q_inst [IQ_DEPTH];
  logic [PC_WIDTH-1:0]   q_pc   [IQ_DEPTH];
  logic [ID_WIDTH-1:0]   q_id   [IQ_DEPTH];
  int                    q_count;
  logic                  exp_a;
  logic                  exp_b;
  int                    exp_slot_b;
  logic                  exp_l0_valid;
  logic                  exp_l1_valid;
  int                    exp_l0_slot;
  int                    exp_l1_slot;
  logic [PC_WIDTH-1:0]   next_pc;
  logic [ID_WIDTH-1:0]   next_id;
  logic                  stall_seen;

  `include "issue_model.svh"

  clock_gen u_clock (.clk(clk));

  issue_stage u_issue_stage (.*);

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("[FAIL] %s: got %h, expected %h", name, got, expected);
      abort_run();
    end
  endtask

  // next mirror state, as of the coming edge.
  task automatic update_mirror();
    int n;
    n = 0;
    if (reset || flush) begin
      q_count = 0;
    end else begin
      for (int k = 0; k < q_count; k++) begin
        if (!(exp_a && k == 0) && !(exp_b && k == exp_slot_b)) begin
          q_inst[n] = q_inst[k];
          q_pc[n]   = q_pc[k];
          q_id[n]   = q_id[k];
          n++;
        end
      end
      if (push0) begin
        q_inst[n] = instruction0_in;
        q_pc[n]   = pc0_in;
        q_id[n]   = id0_in;
        n++;
      end
      if (push1) begin
        q_inst[n] = instruction1_in;
        q_pc[n]   = pc1_in;
        q_id[n]   = id1_in;
        n++;
      end
      q_count = n;
    end
  endtask

  //////////////////////////////////////////////////
  // compare, away from the driving edge.
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      predict(flush);
      check_field("lane0_valid", lane0_valid, exp_l0_valid);
      check_field("lane1_valid", lane1_valid, exp_l1_valid);
      if (exp_l0_valid) begin
        check_field("lane0_instruction", lane0_instruction, q_inst[exp_l0_slot]);
        check_field("lane0_pc", lane0_pc, q_pc[exp_l0_slot]);
        check_field("lane0_id", lane0_id, q_id[exp_l0_slot]);
      end
      if (exp_l1_valid) begin
        check_field("lane1_instruction", lane1_instruction, q_inst[exp_l1_slot]);
        check_field("lane1_pc", lane1_pc, q_pc[exp_l1_slot]);
        check_field("lane1_id", lane1_id, q_id[exp_l1_slot]);
      end
      check_field("free", free, IQ_DEPTH - q_count);
      check_field("stall", stall, (IQ_DEPTH - q_count) < 2);
      if (stall) stall_seen = 1'b1;
    end
    update_mirror();
  end

  //////////////////////////////////////////////////
  // stimulus.
  //////////////////////////////////////////////////

  function automatic logic [INST_WIDTH-1:0] encode(opcode_t op, int rs, int rt, int rd);
    return {op, 5'(rs), 5'(rt), 5'(rd), 11'h0};
  endfunction

  function automatic logic [INST_WIDTH-1:0] random_inst();
    return encode(OP_LIST[$urandom_range(0, 14)], $urandom_range(0, 7),
                  $urandom_range(0, 7), $urandom_range(0, 7));
  endfunction

  // one push cycle, held back while the queue is stalled.
  task automatic push_cycle(input logic p0, input logic p1,
                            input logic [INST_WIDTH-1:0] i0, input logic [INST_WIDTH-1:0] i1);
    int waited;
    waited = 0;
    @(posedge clk);
    while ((p0 || p1) && (IQ_DEPTH - q_count) < 2) begin
      push0 <= 1'b0;
      push1 <= 1'b0;
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: queue stayed stalled");
        abort_run();
      end
      @(posedge clk);
    end
    push0           <= p0;
    push1           <= p1;
    instruction0_in <= i0;
    instruction1_in <= i1;
    pc0_in          <= next_pc;
    pc1_in          <= next_pc + 32'd4;
    id0_in          <= next_id;
    id1_in          <= next_id + 1'b1;
    next_pc = next_pc + 32'd8;
    next_id = next_id + 2'd2;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      push0 <= 1'b0;
      push1 <= 1'b0;
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: queue did not drain");
        abort_run();
      end
    end while (q_count != 0);
  endtask

  task automatic push_and_drain(input logic [INST_WIDTH-1:0] i0,
                                input logic [INST_WIDTH-1:0] i1);
    push_cycle(1'b1, 1'b1, i0, i1);
    drain();
  endtask

  // two loads keep one entry ahead, so the next pair lands at slots 1 and 2.
  task automatic lead_with_loads();
    push_cycle(1'b1, 1'b1, encode(OP_LW, 20, 21, 0), encode(OP_LW, 22, 23, 0));
  endtask

  task automatic flush_cycle();
    @(posedge clk);
    push0 <= 1'b0;
    push1 <= 1'b0;
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  initial begin
    int lanes;
    void'($urandom(32'h2e2c_e5aa));
    reset           = 1'b1;
    flush           = 1'b0;
    push0           = 1'b0;
    push1           = 1'b0;
    instruction0_in = '0;
    instruction1_in = '0;
    pc0_in          = '0;
    pc1_in          = '0;
    id0_in          = '0;
    id1_in          = '0;
    next_pc         = 32'h0000_1000;
    next_id         = '0;
    q_count         = 0;
    stall_seen      = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // reset state, then loads that issue one per cycle fill the queue.
    @(negedge clk);
    check_field("free", free, IQ_DEPTH);
    check_field("stall", stall, 1'b0);
    for (int n = 0; n < 8; n++) begin
      push_cycle(1'b1, 1'b1, encode(OP_LW, 20, n, 0), encode(OP_LW, 21, n + 8, 0));
    end
    drain();
    assert (stall_seen) else begin
      $display("stall never rose while the queue filled");
      abort_run();
    end

    // independent pairs across the pipe classes.
    push_and_drain(encode(OP_ADD, 2, 3, 1), encode(OP_LW, 4, 5, 0));
    push_and_drain(encode(OP_LW, 6, 7, 0), encode(OP_ADDI, 8, 9, 0));
    push_and_drain(encode(OP_JE, 0, 0, 0), encode(OP_SUB, 10, 11, 12));
    push_and_drain(encode(OP_ADD, 13, 14, 15), encode(OP_JE, 0, 0, 0));
    push_and_drain(encode(OP_SW, 13, 14, 0), encode(OP_JMP, 0, 0, 0));
    push_and_drain(encode(OP_ADD, 15, 16, 17), encode(OP_CMPI, 18, 19, 0));

    // register hazards, at slot 0 and deeper.
    push_and_drain(encode(OP_ADD, 2, 3, 1), encode(OP_SUB, 1, 5, 4));
    push_and_drain(encode(OP_ADD, 2, 3, 1), encode(OP_ADDI, 6, 2, 0));
    push_and_drain(encode(OP_ADD, 2, 3, 1), encode(OP_ADDI, 6, 1, 0));
    lead_with_loads();
    push_and_drain(encode(OP_SW, 2, 3, 0), encode(OP_ADDI, 4, 2, 0));
    lead_with_loads();
    push_and_drain(encode(OP_LW, 9, 7, 0), encode(OP_ADDI, 4, 7, 0));

    // ordering rules.
    push_cycle(1'b1, 1'b1, encode(OP_ADD, 2, 3, 1), encode(OP_ADD, 1, 3, 7));
    // the store sits behind a load stalled on r7.
    push_and_drain(encode(OP_LW, 7, 10, 0), encode(OP_SW, 8, 9, 0));
    lead_with_loads();
    push_and_drain(encode(OP_SW, 1, 2, 0), encode(OP_JE, 0, 0, 0));
    lead_with_loads();
    push_and_drain(encode(OP_CMP, 1, 2, 3), encode(OP_JO, 0, 0, 0));

    // random mixed traffic over a small register set.
    for (int n = 0; n < 120; n++) begin
      lanes = $urandom_range(0, 2);
      push_cycle(lanes > 0, lanes > 1, random_inst(), random_inst());
    end
    drain();

    // flush with entries still queued.
    lead_with_loads();
    lead_with_loads();
    flush_cycle();
    @(negedge clk);
    check_field("free", free, IQ_DEPTH);

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+sim
common/isa_pkg.sv
common/iq_pkg.sv
hdl/reg_decode.sv
queue/issue_queue.sv
queue/occupancy_counter.sv
select/order_hazard.sv
select/dual_select.sv
hdl/issue_stage.sv
sim/clock_gen.sv
sim/tb_issue_stage.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  - common/isa_pkg.sv
  - common/iq_pkg.sv
  - hdl/reg_decode.sv
  - queue/issue_queue.sv
  - queue/occupancy_counter.sv
  - select/order_hazard.sv
  - select/dual_select.sv
  - hdl/issue_stage.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/clock_gen.sv
      - sim/tb_issue_stage.sv
